//--- bench/alu_block_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_block_tb import alu_pkg::*; ();

    localparam code_t NO_LOAD = 4'd8;

    logic      clk;
    logic      rst_n;
    ctl_word_t ctl;
    byte_t     bus_in;
    byte_t     bus_out;
    flags_t    fout;

    // reference state
    byte_t  regs_m [4];
    flags_t flags_m;
    int     errors;
    int     checks;

    alu_block dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctl     (ctl),
        .bus_in  (bus_in),
        .bus_out (bus_out),
        .fout    (fout)
    );

    always #5 clk = ~clk;

    function automatic ctl_word_t make_ctl(input code_t src, input code_t dst,
                                           input logic [1:0] al, input logic [2:0] ar,
                                           input logic alt, input logic calc,
                                           input logic cin);
        ctl_word_t c;
        c.outctl  = src;
        c.loadctl = dst;
        c.arg_l   = al;
        c.arg_r   = ar;
        c.alt     = alt;
        c.calc    = calc;
        c.cin     = cin;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    // expected bus value and next flags from the current model state
    task automatic predict(input ctl_word_t c, input byte_t ext,
                           output byte_t exp_bus, output flags_t exp_f);
        byte_t l;
        byte_t r;
        int    sum;
        int    res;
        logic  cy;
        logic  ov;
        logic  c_en;
        logic  v_en;
        l    = regs_m[c.arg_l];
        r    = (c.arg_r < 3'd4) ? regs_m[c.arg_r[1:0]] : 8'h00;
        cy   = 1'b0;
        ov   = 1'b0;
        c_en = 1'b0;
        v_en = 1'b0;
        case (c.outctl)
            `A_OUT, `B_OUT, `C_OUT, `D_OUT: exp_bus = regs_m[c.outctl[1:0]];
            `F_OUT: exp_bus = {4'b0, flags_m};
            `ADDSUB_OUT: begin
                if (c.alt) begin
                    sum = int'(l) + (255 - int'(r)) + int'(c.cin);
                    res = int'($signed(l)) - int'($signed(r)) - 1 + int'(c.cin);
                end else begin
                    sum = int'(l) + int'(r) + int'(c.cin);
                    res = int'($signed(l)) + int'($signed(r)) + int'(c.cin);
                end
                exp_bus = byte_t'(sum);
                cy      = (sum > 255);
                ov      = (res > 127) || (res < -128);
                c_en    = 1'b1;
                v_en    = 1'b1;
            end
            `ANDOR_OUT: exp_bus = c.alt ? (l | r) : (l & r);
            `SHIFTSWAP_OUT: begin
                exp_bus = c.alt ? {l[3:0], l[7:4]} : {l[6:0], c.cin};
                cy      = l[7];
                c_en    = !c.alt;
            end
            `XORNOT_OUT: exp_bus = c.alt ? ~l : (l ^ r);
            `EXT_OUT: exp_bus = ext;
            default: exp_bus = 8'hFF;
        endcase
        exp_f = flags_m;
        if (c.loadctl == `F_LOAD) begin
            exp_f = flags_t'(exp_bus[3:0]);
        end else if (c.calc) begin
            exp_f.n = exp_bus[7];
            exp_f.z = (exp_bus == 8'h00);
            if (c_en) exp_f.c = cy;
            if (v_en) exp_f.v = ov;
        end
    endtask

    // one cycle, entered and left on a falling edge
    task automatic step(input ctl_word_t c, input byte_t ext);
        byte_t  exp_bus;
        flags_t exp_f;
        predict(c, ext, exp_bus, exp_f);
        ctl    = c;
        bus_in = ext;
        #1;
        check_value("bus_out", bus_out, exp_bus);
        @(negedge clk);
        if (c.loadctl < 4'd4) regs_m[c.loadctl[1:0]] = exp_bus;
        flags_m = exp_f;
        check_value("fout", {4'b0, fout}, {4'b0, flags_m});
    endtask

    task automatic load_ext(input code_t dst, input byte_t value);
        step(make_ctl(`EXT_OUT, dst, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0), value);
    endtask

    task automatic read_src(input code_t src);
        step(make_ctl(src, NO_LOAD, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0), 8'h00);
    endtask

    task automatic read_all_regs();
        for (int i = 0; i < 4; i++) read_src(code_t'(i));
    endtask

    task automatic reset_readback();
        check_value("fout", {4'b0, fout}, 8'h00);
        read_all_regs();
        read_src(`F_OUT);
    endtask

    task automatic load_readback();
        code_t unused_src [6] = '{4'd8, 4'd9, 4'd11, 4'd12, 4'd13, 4'd14};
        code_t no_target [6] = '{4'd4, 4'd5, 4'd6, 4'd8, 4'd12, 4'd15};
        for (int i = 0; i < 4; i++) load_ext(code_t'(i), byte_t'($urandom));
        read_all_regs();
        foreach (unused_src[i]) read_src(unused_src[i]);
        foreach (no_target[i]) load_ext(no_target[i], byte_t'($urandom));
        read_all_regs();
    endtask

    task automatic do_addsub(input byte_t l, input byte_t r, input logic alt,
                             input logic cin);
        load_ext(`A_LOAD, l);
        load_ext(`B_LOAD, r);
        step(make_ctl(`ADDSUB_OUT, `C_LOAD, 2'd0, 3'd1, alt, 1'b1, cin), 8'h00);
        read_src(`C_OUT);
    endtask

    task automatic addsub_results();
        byte_t edge_l [4] = '{8'h7F, 8'h80, 8'hFF, 8'h00};
        byte_t edge_r [4] = '{8'h01, 8'h01, 8'h01, 8'h00};
        for (int k = 0; k < 4; k++) begin
            foreach (edge_l[i]) do_addsub(edge_l[i], edge_r[i], k[1], k[0]);
        end
        for (int i = 0; i < 24; i++) begin
            do_addsub(byte_t'($urandom), byte_t'($urandom), i[0], i[1]);
        end
    endtask

    task automatic logic_results();
        logic [2:0] zero_codes [4] = '{3'd4, 3'd5, `ARG_ZERO, 3'd7};
        load_ext(`A_LOAD, byte_t'($urandom));
        load_ext(`B_LOAD, byte_t'($urandom));
        // v and c set so that a wrong update shows
        load_ext(`F_LOAD, 8'h03);
        for (int k = 0; k < 2; k++) begin
            step(make_ctl(`ANDOR_OUT, NO_LOAD, 2'd0, 3'd1, k[0], 1'b1, 1'b0), 8'h00);
            step(make_ctl(`XORNOT_OUT, NO_LOAD, 2'd0, 3'd1, k[0], 1'b1, 1'b0), 8'h00);
        end
        check_value("fout.vc", {6'b0, fout.v, fout.c}, 8'h03);
        foreach (zero_codes[i]) begin
            step(make_ctl(`ADDSUB_OUT, NO_LOAD, 2'd1, zero_codes[i], 1'b0, 1'b0, 1'b0),
                 8'h00);
            step(make_ctl(`ANDOR_OUT, NO_LOAD, 2'd1, zero_codes[i], 1'b0, 1'b1, 1'b0),
                 8'h00);
        end
    endtask

    task automatic shift_and_flag_access();
        load_ext(`F_LOAD, 8'h00);
        load_ext(`A_LOAD, byte_t'($urandom) | 8'h80);
        load_ext(`B_LOAD, byte_t'($urandom) & 8'h7F);
        step(make_ctl(`SHIFTSWAP_OUT, NO_LOAD, 2'd0, 3'd0, 1'b0, 1'b1, 1'($urandom)),
             8'h00);
        // swap of B must leave the carry set although B[7] is clear
        step(make_ctl(`SHIFTSWAP_OUT, `A_LOAD, 2'd1, 3'd0, 1'b1, 1'b1, 1'b0), 8'h00);
        step(make_ctl(`SHIFTSWAP_OUT, NO_LOAD, 2'd1, 3'd0, 1'b0, 1'b1, 1'b1), 8'h00);
        load_ext(`F_LOAD, 8'hA5);
        read_src(`F_OUT);
        check_value("bus_out", bus_out, 8'h05);
        step(make_ctl(`ADDSUB_OUT, `F_LOAD, 2'd0, 3'd1, 1'b0, 1'b1, 1'b1), 8'h00);
        read_src(`F_OUT);
    endtask

    task automatic flags_without_calc();
        load_ext(`F_LOAD, 8'h0A);
        step(make_ctl(`ADDSUB_OUT, NO_LOAD, 2'd0, 3'd1, 1'b1, 1'b0, 1'b0), 8'h00);
        step(make_ctl(`SHIFTSWAP_OUT, NO_LOAD, 2'd2, 3'd0, 1'b0, 1'b0, 1'b1), 8'h00);
        check_value("fout", {4'b0, fout}, 8'h0A);
    endtask

    initial begin
        void'($urandom(32'h416a_7ba2));
        errors  = 0;
        checks  = 0;
        clk     = 1'b0;
        rst_n   = 1'b0;
        ctl     = make_ctl(4'd8, NO_LOAD, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0);
        bus_in  = 8'h00;
        flags_m = '0;
        foreach (regs_m[i]) regs_m[i] = 8'h00;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_readback();
        load_readback();
        addsub_results();
        logic_results();
        shift_and_flag_access();
        flags_without_calc();
        ctl = make_ctl(4'd8, NO_LOAD, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
src/alu_pkg.sv
src/reg_file.sv
src/alu_core.sv
src/bus_select.sv
src/flags_reg.sv
src/alu_block.sv
bench/alu_block_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ns -f compile.f \
    --top-module alu_block_tb -o alu_block_sim
./obj_dir/alu_block_sim > sim.log 2>&1
cat sim.log
grep -q "Testbench passed" sim.log

//--- src/alu_block.sv
`timescale 1ns/1ns
`default_nettype none

module alu_block import alu_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire ctl_word_t ctl,
    input  wire byte_t     bus_in,
    output byte_t          bus_out,
    output flags_t         fout
);

    reg_bank_t regs;
    byte_t     alu_l;
    byte_t     alu_r;
    alu_out_t  units;
    flag_upd_t upd;

    reg_file regs0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (bus_out),
        .loadctl (ctl.loadctl),
        .arg_l   (ctl.arg_l),
        .arg_r   (ctl.arg_r),
        .regs    (regs),
        .alu_l   (alu_l),
        .alu_r   (alu_r)
    );

    alu_core core0 (
        .l     (alu_l),
        .r     (alu_r),
        .alt   (ctl.alt),
        .cin   (ctl.cin),
        .units (units)
    );

    // single driver of the shared bus
    bus_select sel0 (
        .outctl (ctl.outctl),
        .alt    (ctl.alt),
        .regs   (regs),
        .units  (units),
        .flags  (fout),
        .ext    (bus_in),
        .bus    (bus_out),
        .upd    (upd)
    );

    flags_reg flags0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (bus_out),
        .loadctl (ctl.loadctl),
        .calc    (ctl.calc),
        .upd     (upd),
        .fout    (fout)
    );

endmodule

`default_nettype wire

//--- src/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// bus source codes
`define A_OUT          4'd0
`define B_OUT          4'd1
`define C_OUT          4'd2
`define D_OUT          4'd3
`define F_OUT          4'd4
`define ADDSUB_OUT     4'd5
`define ANDOR_OUT      4'd6
`define SHIFTSWAP_OUT  4'd7
`define XORNOT_OUT     4'd10
`define EXT_OUT        4'd15

// load target codes
`define A_LOAD         4'd0
`define B_LOAD         4'd1
`define C_LOAD         4'd2
`define D_LOAD         4'd3
`define F_LOAD         4'd7

// right operand code that reads zero
`define ARG_ZERO       3'd6

// undriven bus reads as pulled high
`define BUS_IDLE       8'hFF

`endif

//--- src/alu_core.sv
`timescale 1ns/1ns
`default_nettype none

module alu_core import alu_pkg::*; (
    input  wire byte_t l,
    input  wire byte_t r,
    input  wire        alt,
    input  wire        cin,
    output alu_out_t   units
);

    byte_t      r_eff;
    logic [8:0] sum;

    // subtract is l + ~r + cin
    always_comb begin
        r_eff = alt ? ~r : r;
        sum   = {1'b0, l} + {1'b0, r_eff} + {8'b0, cin};
    end

    always_comb begin
        units.addsub = sum[7:0];
        units.add_c  = sum[8];
        // signed overflow when both inputs agree in sign and the result does not
        units.add_v  = (l[7] == r_eff[7]) && (sum[7] != l[7]);
    end

    always_comb begin
        if (alt) begin
            units.andor = l | r;
        end else begin
            units.andor = l & r;
        end
    end

    always_comb begin
        if (alt) begin
            units.xornot = ~l;
        end else begin
            units.xornot = l ^ r;
        end
    end

    // rotate left through carry, or nibble swap
    always_comb begin
        if (alt) begin
            units.shiftswap = {l[3:0], l[7:4]};
        end else begin
            units.shiftswap = {l[6:0], cin};
        end
        units.shift_c = l[7];
    end

endmodule

`default_nettype wire

//--- src/alu_pkg.sv
`default_nettype none

package alu_pkg;

    typedef logic [7:0] byte_t;

    // bus source or load target
    typedef logic [3:0] code_t;

    typedef struct packed {
        code_t      outctl;
        code_t      loadctl;
        logic [1:0] arg_l;
        logic [2:0] arg_r;
        logic       alt;
        logic       calc;
        logic       cin;
    } ctl_word_t;

    // n in bit 3 down to c in bit 0
    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } flags_t;

    // index 0 is register A, the low byte
    typedef byte_t [3:0] reg_bank_t;

    typedef struct packed {
        byte_t addsub;
        byte_t andor;
        byte_t xornot;
        byte_t shiftswap;
        logic  add_c;
        logic  add_v;
        logic  shift_c;
    } alu_out_t;

    typedef struct packed {
        logic c;
        logic v;
        logic c_en;
        logic v_en;
    } flag_upd_t;

endpackage

`default_nettype wire

//--- src/bus_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module bus_select import alu_pkg::*; (
    input  wire code_t     outctl,
    input  wire            alt,
    input  wire reg_bank_t regs,
    input  wire alu_out_t  units,
    input  wire flags_t    flags,
    input  wire byte_t     ext,
    output byte_t          bus,
    output flag_upd_t      upd
);

    always_comb begin
        upd = '0;
        case (outctl)
            `A_OUT: bus = regs[0];
            `B_OUT: bus = regs[1];
            `C_OUT: bus = regs[2];
            `D_OUT: bus = regs[3];
            `F_OUT: bus = {4'b0, flags};
            `ADDSUB_OUT: begin
                bus      = units.addsub;
                upd.c    = units.add_c;
                upd.v    = units.add_v;
                upd.c_en = 1'b1;
                upd.v_en = 1'b1;
            end
            `ANDOR_OUT: bus = units.andor;
            `SHIFTSWAP_OUT: begin
                bus      = units.shiftswap;
                upd.c    = units.shift_c;
                // swap has no carry out
                upd.c_en = !alt;
            end
            `XORNOT_OUT: bus = units.xornot;
            `EXT_OUT: bus = ext;
            default: bus = `BUS_IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- src/flags_reg.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module flags_reg import alu_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire byte_t     bus,
    input  wire code_t     loadctl,
    input  wire            calc,
    input  wire flag_upd_t upd,
    output flags_t         fout
);

    logic load;

    always_comb begin
        load = (loadctl == `F_LOAD);
    end

    // a bus load takes priority over calc
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fout <= '0;
        end else if (load) begin
            fout <= flags_t'(bus[3:0]);
        end else if (calc) begin
            fout.n <= bus[7];
            fout.z <= (bus == 8'h00);
            if (upd.c_en) begin
                fout.c <= upd.c;
            end
            if (upd.v_en) begin
                fout.v <= upd.v;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module reg_file import alu_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire byte_t bus,
    input  wire code_t loadctl,
    input  wire [1:0]  arg_l,
    input  wire [2:0]  arg_r,
    output reg_bank_t  regs,
    output byte_t      alu_l,
    output byte_t      alu_r
);

    // load from the bus, one target per cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            case (loadctl)
                `A_LOAD: begin
                    regs[0] <= bus;
                end
                `B_LOAD: begin
                    regs[1] <= bus;
                end
                `C_LOAD: begin
                    regs[2] <= bus;
                end
                `D_LOAD: begin
                    regs[3] <= bus;
                end
                default: begin
                    // F_LOAD and unused codes leave the bank alone
                end
            endcase
        end
    end

    // left operand always comes from one of A to D
    always_comb begin
        alu_l = regs[arg_l];
    end

    always_comb begin
        case (arg_r)
            3'd0, 3'd1, 3'd2, 3'd3: begin
                alu_r = regs[arg_r[1:0]];
            end
            default: begin
                // ARG_ZERO and codes 4, 5 and 7 have no source
                alu_r = '0;
            end
        endcase
    end

endmodule

`default_nettype wire
